//--- rtl/cps2Decoder.sv
`default_nettype none
`timescale 1ns/1ps

module cps2Decoder #(
    parameter int BETA_PATCH = 0,                 // Passed to the loader
    parameter int ADDR_W     = 24                 // Passed to the pipeline
) (
    input  wire                clk,
    input  wire                rst,
    input  wire  [7:0]         keyByte,           // Key load port
    input  wire                keyStrobe,
    input  wire                fetchValid,        // Opcode fetch port
    input  wire  [ADDR_W-1:0]  fetchAddr,
    input  wire  [15:0]        fetchData,
    output logic               opValid,           // Decrypted opcode, 2 cycles later
    output logic [15:0]        opData
);

    import cps2Pkg::*;

    logic [KEY_W-1:0] cipherKey;                  // Static while fetches run
    logic [RNG_W-1:0] addrLimit;

    cps2KeyLoader #(
        .BETA_PATCH (BETA_PATCH)
    ) u_loader (
        .clk       (clk),
        .rst       (rst),
        .keyByte   (keyByte),
        .keyStrobe (keyStrobe),
        .cipherKey (cipherKey),
        .addrLimit (addrLimit)
    );

    cps2OpcodeDecrypt #(
        .ADDR_W (ADDR_W)
    ) u_decrypt (
        .clk        (clk),
        .rst        (rst),
        .cipherKey  (cipherKey),
        .addrLimit  (addrLimit),
        .fetchValid (fetchValid),
        .fetchAddr  (fetchAddr),
        .fetchData  (fetchData),
        .opValid    (opValid),
        .opData     (opData)
    );

endmodule

`default_nettype wire

//--- rtl/cps2FeistelRound.sv
`default_nettype none
`timescale 1ns/1ps

module cps2FeistelRound (
    input  wire  cps2Pkg::opWord_t roundIn,       // Word entering the round
    input  wire  [7:0]             subKey,        // Round key byte
    output cps2Pkg::opWord_t       roundOut       // Word leaving the round
);

    logic [7:0] mixed;                            // Lo half whitened by the key
    logic [7:0] sumByte;                          // Key added back, wraps at 256
    logic [7:0] roundFn;                          // F output

    assign mixed   = roundIn.half.lo ^ subKey;
    assign sumByte = subKey + mixed;              // Carry out dropped
    assign roundFn = {sumByte[6:0], sumByte[7]};  // Rotate left by one

    // Halves swap every round
    assign roundOut.half.hi = roundIn.half.lo;
    assign roundOut.half.lo = roundIn.half.hi ^ roundFn;

endmodule

`default_nettype wire

//--- rtl/cps2KeyLoader.sv
`default_nettype none
`timescale 1ns/1ps

module cps2KeyLoader #(
    parameter int BETA_PATCH = 0                  // 1 forces low key bits on beta boards
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  [7:0]                    keyByte,     // Serial key byte
    input  wire                           keyStrobe,   // Level, one byte per rising edge
    output logic [cps2Pkg::KEY_W-1:0]     cipherKey,
    output logic [cps2Pkg::RNG_W-1:0]     addrLimit
);

    import cps2Pkg::*;

    logic             strobeReg;                  // Strobe sampled once
    logic             strobeLast;                 // Previous sample for edge detect
    logic [7:0]       byteReg;                    // Byte sampled with strobeReg
    logic             byteTake;                   // Rising edge seen this cycle
    logic [RAW_W-1:0] rawKey;                     // Serial shift register
    logic [SUM_W-1:0] keySum;                     // Running byte sum
    logic             betaFlag;                   // Board not on known list
    logic [RAW_W-1:0] cfgWord;                    // Unscrambled configuration
    logic [KEY_W-1:0] betaMask;                   // Low key bits forced on beta

    assign byteTake = strobeReg & ~strobeLast;    // One pulse per strobe rise

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            strobeReg  <= 1'b0;
            strobeLast <= 1'b0;
        end else begin
            strobeReg  <= keyStrobe;
            strobeLast <= strobeReg;
        end
    end

    // Byte travels alongside strobeReg so both line up at the capture edge
    always_ff @(posedge clk) begin
        byteReg <= keyByte;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rawKey <= '0;
            keySum <= '0;
        end else if (byteTake) begin
            rawKey <= {byteReg, rawKey[RAW_W-1:8]};              // New byte enters on top
            keySum <= keySum + {{(SUM_W-8){1'b0}}, byteReg};     // Modulo 4096
        end
    end

    // Checked every cycle, trails the checksum by one clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            betaFlag <= 1'b1;                     // No key yet counts as unknown
        end else begin
            betaFlag <= ~cps2KnownSum(keySum);
        end
    end

    assign cfgWord = cps2Unscramble(rawKey);      // Pure bit shuffle

    always_comb begin
        betaMask = '0;
        if (BETA_PATCH != 0)
            betaMask[9:0] = {10{betaFlag}};       // Only the low 10 bits
    end

    assign cipherKey = cfgWord[KEY_W-1:0] | betaMask;
    assign addrLimit = cfgWord[RAW_W-1 -: RNG_W];              // Top halfword of config

endmodule

`default_nettype wire

//--- rtl/cps2OpcodeDecrypt.sv
`default_nettype none
`timescale 1ns/1ps

module cps2OpcodeDecrypt #(
    parameter int ADDR_W = 24                     // Fetch address width, at least RNG_W
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire  [cps2Pkg::KEY_W-1:0]     cipherKey,   // Level from loader
    input  wire  [cps2Pkg::RNG_W-1:0]     addrLimit,   // Decrypt below this
    input  wire                           fetchValid,  // One-cycle fetch pulse
    input  wire  [ADDR_W-1:0]             fetchAddr,
    input  wire  [15:0]                   fetchData,   // Encrypted word
    output logic                          opValid,     // Two cycles after fetchValid
    output logic [15:0]                   opData
);

    import cps2Pkg::*;

    logic [7:0]  subKey [4];                      // One byte per round
    opWord_t     rIn    [4];                      // Round inputs
    opWord_t     rOut   [4];                      // Round outputs
    logic        inRange;                         // Fetch below the limit

    logic        s1Valid;                         // Stage 1 holds a word
    logic [15:0] s1Orig;                          // Untouched word for pass-through
    logic        s1InRange;
    opWord_t     s1Mid;                           // Half-decrypted word

    // Subkey k folds key byte k with key byte k+4
    for (genvar k = 0; k < 4; k++) begin : gSubKey
        assign subKey[k] = cipherKey[8*k +: 8] ^ cipherKey[8*(k+4) +: 8];
    end

    always_comb begin
        rIn[0].word = fetchData;                  // Stage 1 chain
        rIn[1]      = rOut[0];
        rIn[2]      = s1Mid;                      // Stage 2 chain
        rIn[3]      = rOut[2];
    end

    for (genvar r = 0; r < 4; r++) begin : gRound
        cps2FeistelRound u_round (
            .roundIn  (rIn[r]),
            .subKey   (subKey[r]),
            .roundOut (rOut[r])
        );
    end

    assign inRange = fetchAddr[ADDR_W-1 -: RNG_W] < addrLimit;   // Strict compare

    // Stage 1 control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1Valid   <= 1'b0;
            s1InRange <= 1'b0;
        end else begin
            s1Valid   <= fetchValid;
            s1InRange <= fetchValid & inRange;
        end
    end

    // Stage 1 payload, loaded only on a fetch
    always_ff @(posedge clk) begin
        if (fetchValid) begin
            s1Orig <= fetchData;
            s1Mid  <= rOut[1];                    // After rounds 0 and 1
        end
    end

    // Stage 2 control
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            opValid <= 1'b0;
        else
            opValid <= s1Valid;
    end

    // Stage 2 payload, held between words
    always_ff @(posedge clk) begin
        if (s1Valid)
            opData <= s1InRange ? rOut[3].word : s1Orig;        // Out of range passes through
    end

endmodule

`default_nettype wire

//--- rtl/cps2Pkg.sv
`default_nettype none

package cps2Pkg;

    localparam int KEY_BYTES = 20;                // Bytes sent per key load
    localparam int RAW_W     = KEY_BYTES * 8;     // Raw shift register width
    localparam int KEY_W     = 64;                // Cipher key width
    localparam int RNG_W     = 16;                // Address limit width
    localparam int SUM_W     = 12;                // Byte checksum width

    // One opcode word, seen whole or as the two Feistel halves
    typedef union packed {
        logic [15:0] word;                        // Whole fetched word
        struct packed {
            logic [7:0] hi;                       // Left half
            logic [7:0] lo;                       // Right half
        } half;
    } opWord_t;

    // Board bit shuffle from raw serial bits to config word
    // Each 16-bit group takes bits 15..10 and 7..0 of one raw halfword
    // plus two bits borrowed from the halfword below it
    function automatic logic [RAW_W-1:0] cps2Unscramble(input logic [RAW_W-1:0] raw);
        logic [RAW_W-1:0] cfg;
        int grp;
        int pos;
        int base;
        int prev;
        int src;
        cfg = '0;
        for (grp = 0; grp < RAW_W / 16; grp++) begin
            case (grp)                            // Key groups swap in pairs
                0:       base = 128;
                1:       base = 144;
                2:       base = 96;
                3:       base = 112;
                default: base = 16 * (9 - grp);   // Limit and upper key go in order
            endcase
            prev = (base + RAW_W - 8) % RAW_W;    // Wraps to the top byte for group 9
            for (pos = 0; pos < 16; pos++) begin  // pos 0 is the group MSB
                if (pos < 6)
                    src = base + 10 + pos;
                else if (pos < 14)
                    src = base + pos - 6;
                else
                    src = prev + pos - 14;
                cfg[16 * grp + 15 - pos] = raw[src];
            end
        end
        return cfg;
    endfunction

    // Checksums of key files from boards known to need no beta patch
    function automatic logic cps2KnownSum(input logic [SUM_W-1:0] sum);
        logic hit;
        case (sum)
            12'h7AC, 12'h7D9, 12'h6F3, 12'h6C2, 12'h4BA, 12'h5EB,
            12'h617, 12'h632, 12'h646, 12'h647, 12'h6C5, 12'h60E,
            12'h725, 12'h59F, 12'h6F8, 12'h743, 12'h70C, 12'h6F5,
            12'h6EB, 12'h683, 12'h51C, 12'h5F9, 12'h604, 12'h4C1,
            12'h741, 12'h76D, 12'h48B, 12'h6CB, 12'h63E, 12'h697,
            12'h5A1, 12'h5BF, 12'h34D, 12'h3CE, 12'h496, 12'h388,
            12'h4B9, 12'h6BB, 12'h5BB, 12'h628, 12'h4BD, 12'h4B5,
            12'h747, 12'h666, 12'h6C0, 12'h6CF, 12'h6ED, 12'h69C:
                hit = 1'b1;                       // Listed board
            default:
                hit = 1'b0;                       // Unknown, treat as beta
        endcase
        return hit;
    endfunction

endpackage

`default_nettype wire

//--- sources.f
rtl/cps2Pkg.sv
rtl/cps2FeistelRound.sv
rtl/cps2KeyLoader.sv
rtl/cps2OpcodeDecrypt.sv
rtl/cps2Decoder.sv
verif/cps2DecoderTb.sv

//--- verif/cps2DecoderTb.sv
`default_nettype none
`timescale 1ns/1ps

module cps2DecoderTb;

    import cps2Pkg::*;

    localparam int ADDR_W     = 24;
    localparam int BETA_PATCH = 1;
    localparam int RESET_CYC  = 3;
    localparam int IDLE_CYC   = 5;                // Quiet time after reset
    localparam int MAX_HOLD   = 3;                // Longest strobe high time
    localparam int SETTLE     = 4;                // Key and beta flag settle
    localparam int LOAD_CYC   = KEY_BYTES * (MAX_HOLD + 1) + SETTLE;
    localparam int N_LOADS    = 4;
    localparam int N_FETCH    = 52;               // Sum over all tests
    localparam int FETCH_CYC  = 4;                // Worst case for a single fetch
    localparam int MARGIN     = 200;
    localparam int TIMEOUT_CYC = RESET_CYC + IDLE_CYC + N_LOADS * LOAD_CYC
                               + N_FETCH * FETCH_CYC + MARGIN;

    logic              clk = 1'b0;
    logic              rst;
    logic [7:0]        keyByte;
    logic              keyStrobe;
    logic              fetchValid;
    logic [ADDR_W-1:0] fetchAddr;
    logic [15:0]       fetchData;
    logic              opValid;
    logic [15:0]       opData;

    integer            seed;                      // $random state
    int                cycle;                     // Posedge counter
    logic [RAW_W-1:0]  tbRaw;                     // Model of the raw shift register
    logic [SUM_W-1:0]  tbSum;                     // Model of the running checksum
    logic [7:0]        keyBuf [KEY_BYTES];        // Next key to send
    logic [15:0]       expQ   [$];                // Expected words in order
    int                cycQ   [$];                // Expected arrival cycle
    string             nameQ  [$];                // Test that issued each fetch

    cps2Decoder #(
        .BETA_PATCH (BETA_PATCH),
        .ADDR_W     (ADDR_W)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .keyByte    (keyByte),
        .keyStrobe  (keyStrobe),
        .fetchValid (fetchValid),
        .fetchAddr  (fetchAddr),
        .fetchData  (fetchData),
        .opValid    (opValid),
        .opData     (opData)
    );

    initial begin
        forever #5 clk = ~clk;                    // 10 ns period
    end

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on first failure");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expV,
                              input logic [31:0] actV);
        if (expV !== actV) begin
            $display("Error: test %s expected 0x%0h actual 0x%0h", name, expV, actV);
            failNow("Value mismatch");
        end
    endtask

    // One Feistel round where hi takes the old lo
    function automatic logic [15:0] roundRef(input logic [15:0] w, input logic [7:0] sk);
        logic [7:0] f;
        f = sk + (w[7:0] ^ sk);
        f = {f[6:0], f[7]};                       // Rotate left by one
        return {w[7:0], w[15:8] ^ f};
    endfunction

    function automatic logic [RNG_W-1:0] modelLimit();
        logic [RAW_W-1:0] cfg;
        cfg = cps2Unscramble(tbRaw);
        return cfg[RAW_W-1 -: RNG_W];
    endfunction

    // Expected opcode from the key bytes sent so far
    function automatic logic [15:0] refOpcode(input logic [ADDR_W-1:0] addr,
                                              input logic [15:0] data);
        logic [RAW_W-1:0] cfg;
        logic [KEY_W-1:0] key;
        logic             beta;
        logic [15:0]      w;
        int               k;
        cfg  = cps2Unscramble(tbRaw);
        key  = cfg[KEY_W-1:0];
        beta = ~cps2KnownSum(tbSum);              // Unknown boards are beta
        if (BETA_PATCH != 0)
            key[9:0] = key[9:0] | {10{beta}};
        w = data;
        if (addr[ADDR_W-1 -: RNG_W] < cfg[RAW_W-1 -: RNG_W]) begin
            for (k = 0; k < 4; k++)
                w = roundRef(w, key[8*k +: 8] ^ key[8*(k+4) +: 8]);
        end
        return w;
    endfunction

    task automatic fillRandom();
        int i;
        for (i = 0; i < KEY_BYTES; i++)
            keyBuf[i] = $random(seed);
    endtask

    // Random bytes that bring the running sum to a listed value
    task automatic fillKnown();
        int need;
        int i;
        int lo;
        int hi;
        logic [31:0] r;
        need = int'((12'h7AC - tbSum) & 12'hFFF);
        for (i = 0; i < KEY_BYTES; i++) begin
            lo = need - 255 * (KEY_BYTES - 1 - i);  // Rest must still fit
            if (lo < 0)
                lo = 0;
            hi = (need > 255) ? 255 : need;
            r  = $random(seed);
            keyBuf[i] = lo + int'(r[15:0]) % (hi - lo + 1);
            need -= keyBuf[i];
        end
    endtask

    task automatic loadKey(input int hold);
        int i;
        for (i = 0; i < KEY_BYTES; i++) begin
            keyByte   = keyBuf[i];
            keyStrobe = 1'b1;
            repeat (hold) @(negedge clk);         // Held high for one byte only
            keyStrobe = 1'b0;
            @(negedge clk);
            tbRaw = {keyBuf[i], tbRaw[RAW_W-1:8]};
            tbSum = tbSum + keyBuf[i];
        end
        repeat (SETTLE) @(negedge clk);
    endtask

    task automatic pickAddr(input logic want, output logic [ADDR_W-1:0] addr);
        int lim;
        int top;
        logic [31:0] r;
        lim = modelLimit();
        r   = $random(seed);
        if (want && lim > 0)
            top = int'(r[15:0]) % lim;            // Strictly below the limit
        else if (!want)
            top = lim + int'(r[15:0]) % (65536 - lim);
        else
            top = r[15:0];                        // Limit 0 leaves nothing in range
        addr = {top[15:0], r[23:16]};
    endtask

    task automatic sendFetch(input string name, input logic [ADDR_W-1:0] addr,
                             input logic [15:0] data);
        fetchValid = 1'b1;
        fetchAddr  = addr;
        fetchData  = data;
        expQ.push_back(refOpcode(addr, data));
        cycQ.push_back(cycle + 2);                // Two edges to opValid
        nameQ.push_back(name);
        @(negedge clk);
        fetchValid = 1'b0;
    endtask

    task automatic waitDrain();
        wait (expQ.size() == 0);
        @(negedge clk);
    endtask

    task automatic runSingles(input int count, input string name);
        int i;
        logic [ADDR_W-1:0] addr;
        logic [15:0] data;
        for (i = 0; i < count; i++) begin
            pickAddr(i % 2 == 0, addr);           // Alternate below and above
            data = $random(seed);
            sendFetch(name, addr, data);
            waitDrain();
        end
    endtask

    task automatic runBurst(input int count, input string name);
        int i;
        logic [31:0] r;
        logic [ADDR_W-1:0] addr;
        for (i = 0; i < count; i++) begin
            r = $random(seed);
            pickAddr(r[0], addr);
            sendFetch(name, addr, r[31:16]);      // No gap between fetches
        end
        waitDrain();
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYC)
            failNow("Timeout, the run did not finish in time");
    end

    // Compare each result against the oldest expected word
    always @(negedge clk) begin
        if (opValid !== 1'b0) begin
            if (expQ.size() == 0) begin
                failNow("opValid went high with no fetch outstanding");
            end else begin
                checkValue({nameQ[0], " data"}, expQ[0], opData);
                checkValue({nameQ[0], " latency"}, cycQ[0], cycle);
                expQ.pop_front();
                cycQ.pop_front();
                nameQ.pop_front();
            end
        end
    end

    initial begin
        seed       = 32'h5a49;
        cycle      = 0;
        tbRaw      = '0;
        tbSum      = '0;
        rst        = 1'b1;
        keyByte    = 8'h00;
        keyStrobe  = 1'b0;
        fetchValid = 1'b0;
        fetchAddr  = '0;
        fetchData  = 16'h0000;
        repeat (RESET_CYC) @(negedge clk);
        rst = 1'b0;
        repeat (IDLE_CYC) @(negedge clk);         // opValid must stay low here
        runSingles(4, "reset pass-through");      // Limit 0 so all pass
        fillRandom();
        loadKey(1);
        runSingles(8, "random key");
        fillKnown();
        loadKey(1);
        runSingles(8, "known sum key");           // Beta flag now 0
        runBurst(12, "back-to-back");
        fillRandom();
        loadKey(MAX_HOLD);                        // Strobe held several clocks
        runSingles(6, "held strobe");
        runBurst(6, "held strobe burst");
        fillRandom();
        loadKey(1);
        runSingles(8, "reload key");
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
